// File: rtl/vendPkg.sv
package vendPkg;

    // panel size and datapath widths
    localparam int NumItems = 9;                // keys 0..8 map to A1..C3
    localparam int MoneyW = 9;                  // cents, up to 511
    localparam int DispW = 14;                  // holds 9999
    localparam int DigitCount = 4;              // seven-segment digits on the board
    localparam int NumCoins = 5;                // nickel, dime, quarter, dollar, five

    typedef logic [MoneyW-1:0] moneyT;          // amount in cents
    typedef logic [DispW-1:0] dispNumT;         // number sent to the display
    typedef logic [3:0] itemIdT;                // 0 none, 1..9 item A1..C3
    typedef moneyT priceTableT [NumItems];      // index 0 is A1
    typedef logic [DigitCount-1:0][3:0] bcdT;   // digit 0 least significant
    typedef logic [7:0] segT;                   // active low, bit 0 is dp

    localparam dispNumT DispMax = 14'd9999;     // display limit, tally saturates here

    // coin values in cents, nickel first
    localparam moneyT CoinValue [NumCoins] = '{
        9'd5,
        9'd10,
        9'd25,
        9'd100,
        9'd500
    };

    // tally weights, one decimal place per denomination
    localparam dispNumT CoinWeight [NumCoins] = '{
        14'd1,
        14'd10,
        14'd100,
        14'd1000,
        14'd5000
    };

    // a price of 0 marks the item out of stock
    localparam priceTableT DefaultPrices = '{
        9'd100,                                 // A1
        9'd0,                                   // A2 sold out
        9'd125,                                 // A3
        9'd175,                                 // B1
        9'd225,                                 // B2
        9'd250,                                 // B3
        9'd100,                                 // C1
        9'd325,                                 // C2
        9'd375                                  // C3
    };

    // segments abcdefg then dp, low lights the segment
    localparam segT SegDigit [10] = '{
        8'b10000001,                            // 0
        8'b11110011,                            // 1
        8'b01001001,                            // 2
        8'b01100001,                            // 3
        8'b00110011,                            // 4
        8'b00100101,                            // 5
        8'b00000101,                            // 6
        8'b11110001,                            // 7
        8'b00000001,                            // 8
        8'b00100001                             // 9
    };

    localparam segT SegMinus = 8'b01111111;     // only segment g lit

endpackage

// File: rtl/coinAcceptor.sv
`timescale 1ns/1ps

module coinAcceptor import vendPkg::*; #(
    parameter int unsigned MaxCredit = 500      // credit ceiling in cents
) (
    input  logic    A1,                         // clock
    input  logic    A2,                         // async reset, active high
    input  logic    nickel,
    input  logic    dime,
    input  logic    quarter,
    input  logic    dollar,
    input  logic    five,
    input  logic    clearAll,                   // cancel from the sale controller
    output logic    coinEvent,                  // some coin strobed this cycle
    output logic    coinAccepted,               // winning coin fits under the ceiling
    output moneyT   nextCredit,                 // credit if the coin is taken
    output moneyT   credit,
    output dispNumT coinTally                   // weighted count of rejected coins
);

    logic [NumCoins-1:0] coinVec;               // bit 0 nickel .. bit 4 five
    logic [2:0]          coinIdx;               // winning denomination
    logic [MoneyW:0]     coinSum;               // one spare bit, 500 + 500 overflows moneyT
    logic [DispW:0]      tallySum;
    dispNumT             tallySat;

    assign coinVec   = {five, dollar, quarter, dime, nickel};
    assign coinEvent = |coinVec;

    always_comb begin
        coinIdx = '0;
        for (int c = NumCoins - 1; c >= 0; c--) begin // downward so the smallest coin wins
            if (coinVec[c]) begin
                coinIdx = 3'(c);
            end
        end
    end

    assign coinSum      = credit + CoinValue[coinIdx];
    assign coinAccepted = coinEvent && (coinSum <= MaxCredit);
    assign nextCredit   = coinSum[MoneyW-1:0];  // only meaningful when accepted

    assign tallySum = coinTally + CoinWeight[coinIdx];
    assign tallySat = (tallySum > DispMax) ? DispMax : tallySum[DispW-1:0]; // clamp at 9999

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit    <= '0;
            coinTally <= '0;
        end else if (clearAll) begin            // cancel wipes money and tally
            credit    <= '0;
            coinTally <= '0;
        end else if (coinAccepted) begin
            credit    <= nextCredit;
        end else if (coinEvent) begin           // over the limit, coin goes back out
            coinTally <= tallySat;
        end
    end

    creditBounded: assert property (@(posedge A1) disable iff (A2) credit <= MaxCredit)
        else $error("credit %0d above ceiling %0d", credit, MaxCredit);

endmodule

// File: rtl/itemPanel.sv
`timescale 1ns/1ps

module itemPanel import vendPkg::*; #(
    parameter priceTableT PriceTable = DefaultPrices
) (
    input  moneyT               credit,         // current inserted money
    input  itemIdT              dispensedItem,  // 0 when nothing bought yet
    output logic [NumItems-1:0] gLed,           // credit covers the price
    output logic [NumItems-1:0] rLed,           // out of stock
    output logic [NumItems-1:0] dLed            // this item was dispensed
);

    always_comb begin
        for (int i = 0; i < NumItems; i++) begin
            // green needs a real price, a sold out slot never goes green
            gLed[i] = (PriceTable[i] != '0) && (credit >= PriceTable[i]);
            rLed[i] = (PriceTable[i] == '0);     // price 0 means sold out
            dLed[i] = (dispensedItem == itemIdT'(i + 1)); // item codes start at 1
        end
    end

endmodule

// File: rtl/saleController.sv
`timescale 1ns/1ps

module saleController import vendPkg::*; #(
    parameter priceTableT PriceTable = DefaultPrices
) (
    input  logic                A1,             // clock
    input  logic                A2,             // async reset, active high
    input  logic [NumItems-1:0] itemKey,        // one bit per item, A1 is bit 0
    input  logic                cancelReset,
    input  logic                coinsDisp,      // show the rejected coin tally
    input  logic                coinEvent,      // from coinAcceptor
    input  logic                coinAccepted,
    input  moneyT               nextCredit,
    input  moneyT               credit,
    input  dispNumT             coinTally,
    output logic                clearAll,       // one cycle clear of credit and tally
    output itemIdT              dispensedItem,  // last item bought
    output dispNumT             dispNum,        // number on the display
    output logic                dispDecimal,    // show as dollars.cents
    output logic                dispNegative    // minus sign on digit 3
);

    logic   anyKey;
    itemIdT keyIdx;                             // lowest pressed key
    moneyT  keyPrice;
    moneyT  spare;                              // credit left after the sale
    moneyT  shortfall;                          // money still missing
    moneyT  change;                             // change from the last purchase

    assign anyKey = |itemKey;

    always_comb begin
        keyIdx = '0;
        for (int k = NumItems - 1; k >= 0; k--) begin // lowest index wins
            if (itemKey[k]) begin
                keyIdx = itemIdT'(k);
            end
        end
    end

    assign keyPrice  = PriceTable[keyIdx];
    assign spare     = credit - keyPrice;       // used only when credit >= price
    assign shortfall = keyPrice - credit;       // used only when credit < price

    // cancel sits below coins and keys in priority
    assign clearAll = cancelReset && !coinEvent && !anyKey;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            dispNum       <= '0;
            dispDecimal   <= 1'b0;
            dispNegative  <= 1'b0;
            change        <= '0;
            dispensedItem <= '0;
        end else if (coinEvent) begin
            if (coinAccepted) begin             // rejected coins leave the display alone
                dispNum      <= dispNumT'(nextCredit);
                dispDecimal  <= 1'b1;
                dispNegative <= 1'b0;
            end
        end else if (anyKey) begin
            if (credit == '0) begin             // no money, just a price check
                dispNum      <= dispNumT'(keyPrice);
                dispDecimal  <= 1'b1;
                dispNegative <= 1'b0;
            end else if (keyPrice != '0) begin  // sold out with credit does nothing
                if (credit >= keyPrice) begin
                    dispNum       <= dispNumT'(spare);
                    dispDecimal   <= 1'b1;
                    dispNegative  <= 1'b0;
                    change        <= spare;     // credit itself is kept
                    dispensedItem <= keyIdx + 1'b1;
                end else begin
                    dispNum      <= dispNumT'(shortfall);
                    dispDecimal  <= 1'b1;
                    dispNegative <= 1'b1;
                end
            end
        end else if (cancelReset) begin
            dispNum       <= '0;
            dispDecimal   <= 1'b0;
            dispNegative  <= 1'b0;
            change        <= '0;
            dispensedItem <= '0;
        end else if (coinsDisp) begin           // tally is a count, no decimal point
            dispNum      <= coinTally;
            dispDecimal  <= 1'b0;
            dispNegative <= 1'b0;
        end
    end

    // a clear must never race a coin into the credit register
    clearNotWithCoin: assert property (@(posedge A1) disable iff (A2) !(clearAll && coinEvent))
        else $error("clearAll raised during a coin event");

endmodule

// File: rtl/bcdConverter.sv
`timescale 1ns/1ps

module bcdConverter import vendPkg::*; (
    input  dispNumT dispNum,                    // binary, 0..9999
    output bcdT     digits                      // digit 0 is the ones place
);

    logic [4*DigitCount-1:0] bcdAcc;            // shift register of the double dabble

    always_comb begin
        bcdAcc = '0;
        for (int i = DispW - 1; i >= 0; i--) begin // msb first
            for (int d = 0; d < DigitCount; d++) begin
                if (bcdAcc[4*d +: 4] >= 4'd5) begin
                    bcdAcc[4*d +: 4] = bcdAcc[4*d +: 4] + 4'd3; // carry lands after the shift
                end
            end
            bcdAcc = {bcdAcc[4*DigitCount-2:0], dispNum[i]};
        end
    end

    assign digits = bcdAcc;                     // same packing, nibble 0 is ones

    // a fifth digit would be dropped, so the producer must keep under the limit
    always_comb begin
        dispNumInRange: assert final ($isunknown(dispNum) || dispNum <= DispMax)
            else $error("display number %0d above %0d", dispNum, DispMax);
    end

endmodule

// File: rtl/displayScanner.sv
`timescale 1ns/1ps

module displayScanner import vendPkg::*; #(
    parameter int unsigned ScanDivW = 17        // divider bits below the digit counter
) (
    input  logic                  A1,           // clock
    input  logic                  A2,           // async reset, active high
    input  bcdT                   digits,       // from bcdConverter
    input  logic                  dispDecimal,  // dp after digit 2
    input  logic                  dispNegative, // minus on digit 3
    output logic [DigitCount-1:0] anx,          // active low digit enables
    output segT                   value         // active low segments of the lit digit
);

    logic [ScanDivW+1:0] scanCnt;               // free running, top two bits pick the digit
    logic [1:0]          digitSel;
    logic [3:0]          curDigit;
    segT                 digitSeg;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            scanCnt <= '0;                      // start on digit 0
        end else begin
            scanCnt <= scanCnt + 1'b1;
        end
    end

    assign digitSel = scanCnt[ScanDivW+1 -: 2];
    assign curDigit = digits[digitSel];

    // one cold, digit 0 gives 1110
    assign anx = ~(DigitCount'(1) << digitSel);

    always_comb begin
        digitSeg = (curDigit > 4'd9) ? '1 : SegDigit[curDigit]; // non bcd nibble stays dark
        value    = digitSeg;
        if ((digitSel == 2'd3) && dispNegative) begin
            value = SegMinus;                   // leading minus replaces the thousands
        end
        if ((digitSel == 2'd2) && dispDecimal) begin
            value[0] = 1'b0;                    // dp after the dollars digit
        end
    end

endmodule

// File: rtl/vendingMachine.sv
`timescale 1ns/1ps

module vendingMachine import vendPkg::*; #(
    parameter priceTableT  PriceTable = DefaultPrices, // 0 marks sold out
    parameter int unsigned MaxCredit  = 500,    // cents
    parameter int unsigned ScanDivW   = 17      // display refresh divider
) (
    input  logic                  A1,           // clock
    input  logic                  A2,           // async reset, active high
    input  logic [NumItems-1:0]   itemKey,      // A1..C3 keys, bit 0 is A1
    input  logic                  nickel,
    input  logic                  dime,
    input  logic                  quarter,
    input  logic                  dollar,
    input  logic                  five,
    input  logic                  cancelReset,
    input  logic                  coinsDisp,
    output logic [NumItems-1:0]   gLed,
    output logic [NumItems-1:0]   rLed,
    output logic [NumItems-1:0]   dLed,
    output logic [DigitCount-1:0] anx,
    output segT                   value
);

    logic    coinEvent;
    logic    coinAccepted;
    logic    clearAll;
    moneyT   nextCredit;
    moneyT   credit;
    dispNumT coinTally;
    itemIdT  dispensedItem;
    dispNumT dispNum;
    logic    dispDecimal;
    logic    dispNegative;
    bcdT     digits;

    coinAcceptor #(
        .MaxCredit (MaxCredit)
    ) u_coinAcceptor (
        .A1           (A1),
        .A2           (A2),
        .nickel       (nickel),
        .dime         (dime),
        .quarter      (quarter),
        .dollar       (dollar),
        .five         (five),
        .clearAll     (clearAll),
        .coinEvent    (coinEvent),
        .coinAccepted (coinAccepted),
        .nextCredit   (nextCredit),
        .credit       (credit),
        .coinTally    (coinTally)
    );

    itemPanel #(
        .PriceTable (PriceTable)
    ) u_itemPanel (
        .credit        (credit),
        .dispensedItem (dispensedItem),
        .gLed          (gLed),
        .rLed          (rLed),
        .dLed          (dLed)
    );

    saleController #(
        .PriceTable (PriceTable)
    ) u_saleController (
        .A1            (A1),
        .A2            (A2),
        .itemKey       (itemKey),
        .cancelReset   (cancelReset),
        .coinsDisp     (coinsDisp),
        .coinEvent     (coinEvent),
        .coinAccepted  (coinAccepted),
        .nextCredit    (nextCredit),
        .credit        (credit),
        .coinTally     (coinTally),
        .clearAll      (clearAll),
        .dispensedItem (dispensedItem),
        .dispNum       (dispNum),
        .dispDecimal   (dispDecimal),
        .dispNegative  (dispNegative)
    );

    bcdConverter u_bcdConverter (
        .dispNum (dispNum),
        .digits  (digits)
    );

    displayScanner #(
        .ScanDivW (ScanDivW)
    ) u_displayScanner (
        .A1           (A1),
        .A2           (A2),
        .digits       (digits),
        .dispDecimal  (dispDecimal),
        .dispNegative (dispNegative),
        .anx          (anx),
        .value        (value)
    );

endmodule

// File: verification/vendingMachineTb.sv
`timescale 1ns/1ps

module vendingMachineTb import vendPkg::*; ();

    localparam int ScanDivW    = 2;                 // fast scan so a check stays short
    localparam int ScanCycles  = 4 << ScanDivW;     // 16 cycles light every digit once
    localparam int MaxCredit   = 500;
    localparam int RandomCoins = 24;
    localparam int FixedEvents = 13;                // tally, cancel, purchases, priority, final
    localparam int NumEvents   = 1 + NumItems + RandomCoins + FixedEvents;
    localparam logic [3:0] AnxPattern [DigitCount] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

    logic                  A1;
    logic                  A2;
    logic [NumItems-1:0]   itemKey;
    logic                  nickel;
    logic                  dime;
    logic                  quarter;
    logic                  dollar;
    logic                  five;
    logic                  cancelReset;
    logic                  coinsDisp;
    logic [NumItems-1:0]   gLed;
    logic [NumItems-1:0]   rLed;
    logic [NumItems-1:0]   dLed;
    logic [DigitCount-1:0] anx;
    segT                   value;

    integer seed = 74;

    // reference model state
    int refCredit = 0;
    int refTally  = 0;
    int refChange = 0;
    int refItem   = 0;                              // 0 none, 1..9 items
    int refDisp   = 0;
    bit refDec    = 1'b0;
    bit refNeg    = 1'b0;
    logic [NumItems-1:0] expG;
    logic [NumItems-1:0] expR;
    logic [NumItems-1:0] expD;

    // checker state
    bit              checkPending = 1'b0;
    int              scanCount    = 0;
    logic [3:0]      seenMask     = '0;
    segT             capSeg [DigitCount];

    vendingMachine #(
        .PriceTable (DefaultPrices),
        .MaxCredit  (MaxCredit),
        .ScanDivW   (ScanDivW)
    ) u_vendingMachine (
        .A1          (A1),
        .A2          (A2),
        .itemKey     (itemKey),
        .nickel      (nickel),
        .dime        (dime),
        .quarter     (quarter),
        .dollar      (dollar),
        .five        (five),
        .cancelReset (cancelReset),
        .coinsDisp   (coinsDisp),
        .gLed        (gLed),
        .rLed        (rLed),
        .dLed        (dLed),
        .anx         (anx),
        .value       (value)
    );

    initial begin
        A1 = 1'b0;
        forever #5 A1 = ~A1;                        // 10 ns period
    end

    function automatic void showNumber(input int num, input bit dec, input bit neg);
        refDisp = num;
        refDec  = dec;
        refNeg  = neg;
    endfunction

    // one event by the machine rules, coins first, then keys, cancel, tally
    function automatic void modelStep(input logic [4:0] coins, input logic [NumItems-1:0] keys,
                                      input logic cancel, input logic showTally);
        int idx;
        int sum;
        int price;
        idx = 0;
        if (coins != '0) begin
            while (!coins[idx]) idx++;              // smallest coin wins
            sum = refCredit + CoinValue[idx];
            if (sum <= MaxCredit) begin
                refCredit = sum;
                showNumber(sum, 1'b1, 1'b0);
            end else begin
                refTally = refTally + CoinWeight[idx]; // rejected, display untouched
                if (refTally > DispMax) refTally = DispMax;
            end
        end else if (keys != '0) begin
            while (!keys[idx]) idx++;               // lowest key wins
            price = DefaultPrices[idx];
            if (refCredit == 0) begin
                showNumber(price, 1'b1, 1'b0);      // price check only
            end else if (price != 0 && refCredit >= price) begin
                refChange = refCredit - price;      // credit stays as it is
                refItem   = idx + 1;
                showNumber(refChange, 1'b1, 1'b0);
            end else if (price != 0) begin
                showNumber(price - refCredit, 1'b1, 1'b1);
            end
        end else if (cancel) begin
            refCredit = 0;
            refTally  = 0;
            refChange = 0;
            refItem   = 0;
            showNumber(0, 1'b0, 1'b0);
        end else if (showTally) begin
            showNumber(refTally, 1'b0, 1'b0);
        end
    endfunction

    function automatic segT expectedSeg(input int pos);
        segT seg;
        int  digit;
        digit = (refDisp / (10 ** pos)) % 10;
        seg   = SegDigit[digit];
        if (pos == 3 && refNeg) seg = SegMinus;
        if (pos == 2 && refDec) seg[0] = 1'b0;      // dp sits after the dollars digit
        return seg;
    endfunction

    function automatic void computeLeds();
        for (int i = 0; i < NumItems; i++) begin
            expG[i] = (DefaultPrices[i] != 0) && (refCredit >= DefaultPrices[i]);
            expR[i] = (DefaultPrices[i] == 0);
            expD[i] = (refItem == i + 1);
        end
    endfunction

    task automatic stopOnMismatch(input string msg);
        $display("** Error @ %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic compareAll();
        computeLeds();
        assert (gLed === expG) else stopOnMismatch($sformatf("gLed %b, expected %b", gLed, expG));
        assert (rLed === expR) else stopOnMismatch($sformatf("rLed %b, expected %b", rLed, expR));
        assert (dLed === expD) else stopOnMismatch($sformatf("dLed %b, expected %b", dLed, expD));
        for (int d = 0; d < DigitCount; d++) begin
            assert (seenMask[d]) else stopOnMismatch($sformatf("anx never selected digit %0d", d));
            assert (capSeg[d] === expectedSeg(d))
                else stopOnMismatch($sformatf("digit %0d segments %b, expected %b",
                                              d, capSeg[d], expectedSeg(d)));
        end
    endtask

    // samples each digit at mid cycle over one full scan, then compares
    always @(negedge A1) begin
        if (checkPending) begin
            for (int d = 0; d < DigitCount; d++) begin
                if (anx == AnxPattern[d]) begin
                    capSeg[d]   = value;
                    seenMask[d] = 1'b1;
                end
            end
            scanCount++;
            if (scanCount == ScanCycles) begin
                compareAll();
                seenMask     = '0;
                scanCount    = 0;
                checkPending = 1'b0;
            end
        end
    end

    task automatic runCheck();
        checkPending = 1'b1;
        wait (!checkPending);                       // checker hands back after the scan
    endtask

    task automatic driveEvent(input logic [4:0] coins, input logic [NumItems-1:0] keys,
                              input logic cancel, input logic showTally);
        @(posedge A1);
        {five, dollar, quarter, dime, nickel} <= coins;
        itemKey     <= keys;
        cancelReset <= cancel;
        coinsDisp   <= showTally;
        @(posedge A1);                              // DUT takes the strobe here
        {five, dollar, quarter, dime, nickel} <= '0;
        itemKey     <= '0;
        cancelReset <= 1'b0;
        coinsDisp   <= 1'b0;
        modelStep(coins, keys, cancel, showTally);
        runCheck();
    endtask

    initial begin
        repeat (NumEvents * 40 + 100) @(posedge A1);
        $display("watchdog expired, the test sequence did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        integer     r;
        logic [4:0] coins;
        A2          <= 1'b1;
        itemKey     <= '0;
        {five, dollar, quarter, dime, nickel} <= '0;
        cancelReset <= 1'b0;
        coinsDisp   <= 1'b0;
        repeat (5) @(posedge A1);
        A2 <= 1'b0;
        runCheck();                                 // idle state after reset
        for (int i = 0; i < NumItems; i++) begin
            driveEvent('0, NumItems'(1) << i, 1'b0, 1'b0); // price check, no credit
        end
        repeat (RandomCoins) begin
            r     = $random(seed);
            coins = 5'b1 << (((r % 5) + 5) % 5);
            driveEvent(coins, '0, 1'b0, 1'b0);
        end
        driveEvent('0, '0, 1'b0, 1'b1);             // tally of rejected coins
        driveEvent('0, '0, 1'b1, 1'b0);             // cancel
        driveEvent(5'b01000, '0, 1'b0, 1'b0);       // dollar
        driveEvent(5'b00100, '0, 1'b0, 1'b0);       // quarter, 1.25 in
        driveEvent('0, 9'b000000100, 1'b0, 1'b0);   // A3 exact price
        driveEvent('0, 9'b000001000, 1'b0, 1'b0);   // B1 short by 0.50
        driveEvent('0, 9'b000000010, 1'b0, 1'b0);   // A2 sold out
        driveEvent('0, 9'b001000000, 1'b0, 1'b0);   // C1 with change
        driveEvent(5'b00001, 9'b000000001, 1'b0, 1'b0); // coin beats key
        driveEvent(5'b00010, '0, 1'b1, 1'b0);       // coin beats cancel
        driveEvent(5'b10000, 9'b100000000, 1'b0, 1'b0); // rejected coin still blocks key
        driveEvent('0, '0, 1'b0, 1'b1);
        driveEvent('0, '0, 1'b1, 1'b0);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: vlog.f
rtl/vendPkg.sv
rtl/coinAcceptor.sv
rtl/itemPanel.sv
rtl/saleController.sv
rtl/bcdConverter.sv
rtl/displayScanner.sv
rtl/vendingMachine.sv
verification/vendingMachineTb.sv

// File: Bender.yml
package:
  name: vendingMachine

sources:
  - rtl/vendPkg.sv
  - rtl/coinAcceptor.sv
  - rtl/itemPanel.sv
  - rtl/saleController.sv
  - rtl/bcdConverter.sv
  - rtl/displayScanner.sv
  - rtl/vendingMachine.sv
  - target: test
    files:
      - verification/vendingMachineTb.sv
